/* src/wb_pkg.sv */
package wb_pkg;

  localparam int DATA_W    = 32;
  localparam int REG_ID_W  = 5;
  localparam int ROB_IDX_W = 3;
  localparam int VADDR_W   = 32;
  localparam int CAUSE_W   = 4;

  localparam int NUM_REGS  = 2 ** REG_ID_W;
  localparam int ROB_DEPTH = 2 ** ROB_IDX_W;

  // Operand and result word shared by every unit
  typedef logic [DATA_W-1:0] data_t;

  typedef logic [REG_ID_W-1:0] reg_id_t;

  typedef logic [ROB_IDX_W-1:0] rob_idx_t;

  // Faulting address carried with a memory exception
  typedef logic [VADDR_W-1:0] vaddr_t;

  typedef logic [CAUSE_W-1:0] excpt_cause_t;

  // ALU_PASS_B completes without a register write
  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_SLL    = 3'd5,
    ALU_SRL    = 3'd6,
    ALU_PASS_B = 3'd7
  } alu_op_t;

endpackage : wb_pkg

/* src/alu_unit.sv */
module alu_unit import wb_pkg::*; #(
  parameter int ALU_DEPTH = 4
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     issue_i,
  input  alu_op_t  op_i,
  input  data_t    a_i,
  input  data_t    b_i,
  input  reg_id_t  wr_reg_i,
  input  rob_idx_t rob_idx_i,
  input  logic     allowed_wb_i,
  output logic     ready_o,
  output logic     is_instr_wb_o,
  output reg_id_t  wr_reg_o,
  output rob_idx_t rob_idx_o,
  output data_t    result_o,
  output logic     credit_o
);

  localparam int PTR_W = (ALU_DEPTH > 1) ? $clog2(ALU_DEPTH) : 1;
  localparam int CNT_W = $clog2(ALU_DEPTH + 1);
  localparam int SH_W  = $clog2(DATA_W);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(ALU_DEPTH - 1);

  data_t    alu_res;
  logic     stg_valid;
  logic     stg_wb;
  data_t    stg_result;
  reg_id_t  stg_wr_reg;
  rob_idx_t stg_rob_idx;

  data_t    fifo_result [ALU_DEPTH];
  reg_id_t  fifo_wr_reg [ALU_DEPTH];
  rob_idx_t fifo_rob_idx [ALU_DEPTH];
  logic     fifo_wb [ALU_DEPTH];

  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;
  logic             pop;

  always_comb begin
    case (op_i)
      ALU_ADD: alu_res = a_i + b_i;
      ALU_SUB: alu_res = a_i - b_i;
      ALU_AND: alu_res = a_i & b_i;
      ALU_OR:  alu_res = a_i | b_i;
      ALU_XOR: alu_res = a_i ^ b_i;
      ALU_SLL: alu_res = a_i << b_i[SH_W-1:0];
      ALU_SRL: alu_res = a_i >> b_i[SH_W-1:0];
      default: alu_res = b_i;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      stg_valid <= 1'b0;
    end else begin
      stg_valid <= issue_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_i) begin
      stg_result  <= alu_res;
      stg_wr_reg  <= wr_reg_i;
      stg_rob_idx <= rob_idx_i;
      stg_wb      <= (op_i != ALU_PASS_B); // Pass-b only completes its ROB entry
    end
  end

  always_ff @(posedge clk_i) begin
    if (stg_valid) begin
      fifo_result[wr_ptr]  <= stg_result;
      fifo_wr_reg[wr_ptr]  <= stg_wr_reg;
      fifo_rob_idx[wr_ptr] <= stg_rob_idx;
      fifo_wb[wr_ptr]      <= stg_wb;
    end
  end

  assign ready_o = (count != '0);
  assign pop     = ready_o & allowed_wb_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_ptr   <= '0;
      wr_ptr   <= '0;
      count    <= '0;
      credit_o <= 1'b0;
    end else begin
      credit_o <= pop; // One credit back per written result
      if (stg_valid) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      case ({stg_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign is_instr_wb_o = fifo_wb[rd_ptr];
  assign wr_reg_o      = fifo_wr_reg[rd_ptr];
  assign rob_idx_o     = fifo_rob_idx[rd_ptr];
  assign result_o      = fifo_result[rd_ptr];

endmodule : alu_unit

/* src/ex_unit.sv */
module ex_unit import wb_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     issue_i,
  input  data_t    a_i,
  input  data_t    b_i,
  input  reg_id_t  wr_reg_i,
  input  rob_idx_t rob_idx_i,
  input  logic     allowed_wb_i,
  output logic     ready_o,
  output reg_id_t  wr_reg_o,
  output rob_idx_t rob_idx_o,
  output data_t    result_o,
  output logic     credit_o
);

  localparam int STEP_W = $clog2(DATA_W);
  localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(DATA_W - 1);

  typedef enum logic [1:0] {
    EX_IDLE,
    EX_BUSY,
    EX_DONE
  } ex_state_t;

  ex_state_t         state;
  logic [STEP_W-1:0] step_cnt;
  data_t             acc;
  data_t             mcand;
  data_t             mplier;
  logic              start;
  logic              pop;

  assign start = issue_i && (state == EX_IDLE);
  assign pop   = ready_o && allowed_wb_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state    <= EX_IDLE;
      step_cnt <= '0;
      credit_o <= 1'b0;
    end else begin
      credit_o <= pop;
      case (state)
        EX_IDLE: begin
          if (start) begin
            state    <= EX_BUSY;
            step_cnt <= '0;
          end
        end
        EX_BUSY: begin
          step_cnt <= step_cnt + 1'b1;
          if (step_cnt == LAST_STEP) begin
            state <= EX_DONE;
          end
        end
        EX_DONE: begin
          if (pop) begin
            state <= EX_IDLE; // Held here while memory or a stall blocks writeback
          end
        end
        default: state <= EX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      acc       <= '0;
      mcand     <= a_i;
      mplier    <= b_i;
      wr_reg_o  <= wr_reg_i;
      rob_idx_o <= rob_idx_i;
    end else if (state == EX_BUSY) begin
      if (mplier[0]) begin
        acc <= acc + mcand; // Bits above DATA_W are dropped
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  assign ready_o  = (state == EX_DONE);
  assign result_o = acc;

endmodule : ex_unit

/* src/wb_arbiter.sv */
module wb_arbiter import wb_pkg::*; (
  input  logic         alu_ready_i,
  input  logic         alu_is_instr_wb_i,
  input  rob_idx_t     alu_rob_idx_i,
  input  reg_id_t      alu_wr_reg_i,
  input  data_t        alu_result_i,
  input  logic         ex_ready_i,
  input  rob_idx_t     ex_rob_idx_i,
  input  reg_id_t      ex_wr_reg_i,
  input  data_t        ex_result_i,
  input  logic         mem_ready_i,
  input  logic         mem_excpt_i,
  input  logic         mem_reg_wr_en_i,
  input  rob_idx_t     mem_rob_idx_i,
  input  reg_id_t      mem_wr_reg_i,
  input  data_t        data_from_mem_i,
  input  vaddr_t       mem_excpt_tval_i,
  input  excpt_cause_t mem_excpt_cause_i,
  output logic         reg_wr_en_o,
  output logic         instr_with_excpt_o,
  output logic         instr_is_completed_o,
  output logic         ex_allowed_wb_o,
  output logic         alu_allowed_wb_o,
  output rob_idx_t     rob_idx_o,
  output reg_id_t      wr_reg_o,
  output data_t        data_to_reg_o,
  output vaddr_t       instr_excpt_tval_o,
  output excpt_cause_t instr_excpt_cause_o
);

  always_comb begin : arbitrate
    reg_wr_en_o          = 1'b0;
    wr_reg_o             = '0;
    data_to_reg_o        = '0;
    instr_is_completed_o = 1'b0;
    instr_with_excpt_o   = 1'b0;
    instr_excpt_tval_o   = '0;
    instr_excpt_cause_o  = '0;
    rob_idx_o            = '0;
    ex_allowed_wb_o      = 1'b1;
    alu_allowed_wb_o     = 1'b1;

    if (mem_ready_i) begin
      // Memory has no back-pressure so it always wins
      ex_allowed_wb_o  = 1'b0;
      alu_allowed_wb_o = 1'b0;
      wr_reg_o         = mem_wr_reg_i;
      data_to_reg_o    = data_from_mem_i;
      rob_idx_o        = mem_rob_idx_i;
      if (mem_excpt_i) begin
        instr_with_excpt_o  = 1'b1; // No register write on a faulting access
        instr_excpt_tval_o  = mem_excpt_tval_i;
        instr_excpt_cause_o = mem_excpt_cause_i;
      end else begin
        instr_is_completed_o = 1'b1;
        reg_wr_en_o          = mem_reg_wr_en_i;
      end
    end else if (ex_ready_i) begin
      alu_allowed_wb_o     = 1'b0;
      reg_wr_en_o          = 1'b1;
      wr_reg_o             = ex_wr_reg_i;
      data_to_reg_o        = ex_result_i;
      rob_idx_o            = ex_rob_idx_i;
      instr_is_completed_o = 1'b1;
    end else if (alu_ready_i) begin
      reg_wr_en_o          = alu_is_instr_wb_i;
      wr_reg_o             = alu_wr_reg_i;
      data_to_reg_o        = alu_result_i;
      rob_idx_o            = alu_rob_idx_i;
      instr_is_completed_o = 1'b1;
    end
  end

endmodule : wb_arbiter

/* src/reg_file.sv */
module reg_file import wb_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    wr_en_i,
  input  reg_id_t wr_reg_i,
  input  data_t   wr_data_i,
  input  reg_id_t rd_addr_i,
  output data_t   rd_data_o
);

  data_t regs [NUM_REGS];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i && (wr_reg_i != '0)) begin
      regs[wr_reg_i] <= wr_data_i;
    end
  end

  // Register 0 reads as zero whatever is stored there
  assign rd_data_o = (rd_addr_i == '0) ? '0 : regs[rd_addr_i];

endmodule : reg_file

/* src/rob_status.sv */
module rob_status import wb_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic         alloc_i,
  input  logic         complete_i,
  input  logic         excpt_i,
  input  rob_idx_t     idx_i,
  input  vaddr_t       tval_i,
  input  excpt_cause_t cause_i,
  output rob_idx_t     alloc_idx_o,
  output logic         full_o,
  output logic         retire_valid_o,
  output rob_idx_t     retire_idx_o,
  output logic         retire_excpt_o,
  output excpt_cause_t retire_cause_o,
  output vaddr_t       retire_tval_o
);

  rob_idx_t             head;
  rob_idx_t             tail;
  logic [ROB_IDX_W:0]   count;
  logic [ROB_DEPTH-1:0] done;
  logic [ROB_DEPTH-1:0] excpt;
  excpt_cause_t         cause [ROB_DEPTH];
  vaddr_t               tval [ROB_DEPTH];
  logic                 do_alloc;
  logic                 do_retire;

  assign full_o      = (count == (ROB_IDX_W + 1)'(ROB_DEPTH));
  assign alloc_idx_o = tail; // Valid in the same cycle as alloc_i
  assign do_alloc    = alloc_i && !full_o;
  assign do_retire   = (count != '0) && done[head];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      head           <= '0;
      tail           <= '0;
      count          <= '0;
      done           <= '0;
      excpt          <= '0;
      retire_valid_o <= 1'b0;
    end else begin
      retire_valid_o <= do_retire;
      if (do_alloc) begin
        done[tail]  <= 1'b0;
        excpt[tail] <= 1'b0;
        tail        <= tail + 1'b1;
      end
      if (complete_i || excpt_i) begin
        done[idx_i] <= 1'b1;
      end
      if (excpt_i) begin
        excpt[idx_i] <= 1'b1;
      end
      if (do_retire) begin
        done[head] <= 1'b0; // Entry is free for the next allocation
        head       <= head + 1'b1;
      end
      case ({do_alloc, do_retire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (excpt_i) begin
      cause[idx_i] <= cause_i;
      tval[idx_i]  <= tval_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_retire) begin
      retire_idx_o   <= head;
      retire_excpt_o <= excpt[head];
      retire_cause_o <= cause[head];
      retire_tval_o  <= tval[head];
    end
  end

endmodule : rob_status

/* src/wb_core.sv */
module wb_core import wb_pkg::*; #(
  parameter int ALU_DEPTH = 4
) (
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic         alu_issue_i,
  input  alu_op_t      alu_op_i,
  input  data_t        alu_a_i,
  input  data_t        alu_b_i,
  input  reg_id_t      alu_wr_reg_i,
  input  rob_idx_t     alu_rob_idx_i,
  output logic         alu_credit_o,
  input  logic         ex_issue_i,
  input  data_t        ex_a_i,
  input  data_t        ex_b_i,
  input  reg_id_t      ex_wr_reg_i,
  input  rob_idx_t     ex_rob_idx_i,
  output logic         ex_credit_o,
  input  logic         mem_ready_i,
  input  logic         mem_excpt_i,
  input  logic         mem_reg_wr_en_i,
  input  reg_id_t      mem_wr_reg_i,
  input  data_t        data_from_mem_i,
  input  rob_idx_t     mem_rob_idx_i,
  input  vaddr_t       mem_excpt_tval_i,
  input  excpt_cause_t mem_excpt_cause_i,
  input  logic         alloc_i,
  output rob_idx_t     alloc_rob_idx_o,
  output logic         rob_full_o,
  output logic         retire_valid_o,
  output rob_idx_t     retire_rob_idx_o,
  output logic         retire_excpt_o,
  output excpt_cause_t retire_cause_o,
  output vaddr_t       retire_tval_o,
  input  reg_id_t      rd_addr_i,
  output data_t        rd_data_o
);

  logic         alu_ready;
  logic         alu_is_instr_wb;
  reg_id_t      alu_wr_reg;
  rob_idx_t     alu_rob_idx;
  data_t        alu_result;
  logic         alu_allowed_wb;
  logic         ex_ready;
  reg_id_t      ex_wr_reg;
  rob_idx_t     ex_rob_idx;
  data_t        ex_result;
  logic         ex_allowed_wb;
  logic         wb_reg_wr_en;
  logic         wb_excpt;
  logic         wb_completed;
  rob_idx_t     wb_rob_idx;
  reg_id_t      wb_wr_reg;
  data_t        wb_data;
  vaddr_t       wb_tval;
  excpt_cause_t wb_cause;

  alu_unit #(.ALU_DEPTH(ALU_DEPTH)) i_alu_unit (
    .clk_i, .rst_i,
    .issue_i(alu_issue_i), .op_i(alu_op_i), .a_i(alu_a_i), .b_i(alu_b_i),
    .wr_reg_i(alu_wr_reg_i), .rob_idx_i(alu_rob_idx_i), .allowed_wb_i(alu_allowed_wb),
    .ready_o(alu_ready), .is_instr_wb_o(alu_is_instr_wb), .wr_reg_o(alu_wr_reg),
    .rob_idx_o(alu_rob_idx), .result_o(alu_result), .credit_o(alu_credit_o)
  );

  ex_unit i_ex_unit (
    .clk_i, .rst_i,
    .issue_i(ex_issue_i), .a_i(ex_a_i), .b_i(ex_b_i), .wr_reg_i(ex_wr_reg_i),
    .rob_idx_i(ex_rob_idx_i), .allowed_wb_i(ex_allowed_wb),
    .ready_o(ex_ready), .wr_reg_o(ex_wr_reg), .rob_idx_o(ex_rob_idx),
    .result_o(ex_result), .credit_o(ex_credit_o)
  );

  wb_arbiter i_wb_arbiter (
    .alu_ready_i(alu_ready), .alu_is_instr_wb_i(alu_is_instr_wb),
    .alu_rob_idx_i(alu_rob_idx), .alu_wr_reg_i(alu_wr_reg), .alu_result_i(alu_result),
    .ex_ready_i(ex_ready), .ex_rob_idx_i(ex_rob_idx), .ex_wr_reg_i(ex_wr_reg),
    .ex_result_i(ex_result),
    .mem_ready_i, .mem_excpt_i, .mem_reg_wr_en_i, .mem_rob_idx_i, .mem_wr_reg_i,
    .data_from_mem_i, .mem_excpt_tval_i, .mem_excpt_cause_i,
    .reg_wr_en_o(wb_reg_wr_en), .instr_with_excpt_o(wb_excpt),
    .instr_is_completed_o(wb_completed), .ex_allowed_wb_o(ex_allowed_wb),
    .alu_allowed_wb_o(alu_allowed_wb), .rob_idx_o(wb_rob_idx), .wr_reg_o(wb_wr_reg),
    .data_to_reg_o(wb_data), .instr_excpt_tval_o(wb_tval), .instr_excpt_cause_o(wb_cause)
  );

  reg_file i_reg_file (
    .clk_i, .rst_i,
    .wr_en_i(wb_reg_wr_en), .wr_reg_i(wb_wr_reg), .wr_data_i(wb_data),
    .rd_addr_i, .rd_data_o
  );

  rob_status i_rob_status (
    .clk_i, .rst_i,
    .alloc_i, .complete_i(wb_completed), .excpt_i(wb_excpt), .idx_i(wb_rob_idx),
    .tval_i(wb_tval), .cause_i(wb_cause),
    .alloc_idx_o(alloc_rob_idx_o), .full_o(rob_full_o), .retire_valid_o,
    .retire_idx_o(retire_rob_idx_o), .retire_excpt_o, .retire_cause_o, .retire_tval_o
  );

endmodule : wb_core

/* tb/tb_wb_core.sv */
module tb_wb_core import wb_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ALU_DEPTH = 4;
  localparam int TIMEOUT   = 400;

  // Expected state of one allocated ROB entry when it retires
  typedef struct packed {
    rob_idx_t     idx;
    logic         exc;
    excpt_cause_t cause;
    vaddr_t       tval;
  } rob_exp_t;

  logic         clk_i, rst_i, alu_issue_i, ex_issue_i, alloc_i;
  logic         mem_ready_i, mem_excpt_i, mem_reg_wr_en_i;
  alu_op_t      alu_op_i;
  data_t        alu_a_i, alu_b_i, ex_a_i, ex_b_i, data_from_mem_i, rd_data_o;
  reg_id_t      alu_wr_reg_i, ex_wr_reg_i, mem_wr_reg_i, rd_addr_i;
  rob_idx_t     alu_rob_idx_i, ex_rob_idx_i, mem_rob_idx_i, alloc_rob_idx_o, retire_rob_idx_o;
  vaddr_t       mem_excpt_tval_i, retire_tval_o;
  excpt_cause_t mem_excpt_cause_i, retire_cause_o;
  logic         alu_credit_o, ex_credit_o, rob_full_o, retire_valid_o, retire_excpt_o;

  data_t        exp_regs [NUM_REGS];
  rob_exp_t     exp_q [$];
  rob_exp_t     head_exp;
  rob_idx_t     next_idx;
  int           alu_credits;
  int           ex_credits;
  logic [31:0]  rng = 32'hbecb;

  wb_core #(.ALU_DEPTH(ALU_DEPTH)) i_wb_core (.*);

  always #50 clk_i = ~clk_i;

  function automatic data_t next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic data_t alu_model(alu_op_t op, data_t a, data_t b);
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      default: return b;
    endcase
  endfunction

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("TESTS FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  // Credits are counted and retirements are checked on the falling edge
  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (alu_credit_o) alu_credits++;
      if (ex_credit_o) ex_credits++;
      assert (alu_credits <= ALU_DEPTH && ex_credits <= 1)
        else fail_now("a unit returned more credits than it was given");
      if (retire_valid_o) begin
        assert (exp_q.size() > 0) else fail_now("an entry retired with nothing outstanding");
        head_exp = exp_q.pop_front();
        assert (retire_rob_idx_o == head_exp.idx) else fail_now($sformatf(
          "Fail retire_rob_idx_o got %h expected %h", retire_rob_idx_o, head_exp.idx));
        assert (retire_excpt_o == head_exp.exc) else fail_now($sformatf(
          "Fail retire_excpt_o got %h expected %h", retire_excpt_o, head_exp.exc));
        if (head_exp.exc) begin
          assert (retire_cause_o == head_exp.cause) else fail_now($sformatf(
            "Fail retire_cause_o got %h expected %h", retire_cause_o, head_exp.cause));
          assert (retire_tval_o == head_exp.tval) else fail_now($sformatf(
            "Fail retire_tval_o got %h expected %h", retire_tval_o, head_exp.tval));
        end
      end
    end
  end

  // Unit 0 needs only a free ROB entry, 1 also an ALU credit, 2 also the ex credit
  task automatic wait_ready(input int unit);
    int   cycles = 0;
    logic ok;
    do begin
      @(negedge clk_i);
      ok = !rob_full_o && (unit == 0 || (unit == 1 && alu_credits > 0) ||
                           (unit == 2 && ex_credits > 0));
      cycles++;
      assert (ok || cycles < TIMEOUT)
        else fail_now("timed out waiting for a credit or a ROB entry");
    end while (!ok);
  endtask

  task automatic claim_entry(input logic exc, input excpt_cause_t cause, input vaddr_t tval,
                             output rob_idx_t idx);
    assert (alloc_rob_idx_o == next_idx) else fail_now($sformatf(
      "Fail alloc_rob_idx_o got %h expected %h", alloc_rob_idx_o, next_idx));
    exp_q.push_back(rob_exp_t'{next_idx, exc, cause, tval});
    idx = next_idx;
    next_idx++;
  endtask

  task automatic issue_alu(input alu_op_t op, input data_t a, input data_t b, input reg_id_t rd);
    rob_idx_t idx;
    wait_ready(1);
    claim_entry(1'b0, '0, '0, idx);
    @(posedge clk_i);
    alloc_i       <= 1'b1;
    alu_issue_i   <= 1'b1;
    alu_op_i      <= op;
    alu_a_i       <= a;
    alu_b_i       <= b;
    alu_wr_reg_i  <= rd;
    alu_rob_idx_i <= idx;
    alu_credits--;
    if (op != ALU_PASS_B && rd != '0) exp_regs[rd] = alu_model(op, a, b);
    @(posedge clk_i);
    alloc_i     <= 1'b0;
    alu_issue_i <= 1'b0;
  endtask

  task automatic issue_ex(input data_t a, input data_t b, input reg_id_t rd);
    rob_idx_t idx;
    wait_ready(2);
    claim_entry(1'b0, '0, '0, idx);
    @(posedge clk_i);
    alloc_i      <= 1'b1;
    ex_issue_i   <= 1'b1;
    ex_a_i       <= a;
    ex_b_i       <= b;
    ex_wr_reg_i  <= rd;
    ex_rob_idx_i <= idx;
    ex_credits--;
    if (rd != '0) exp_regs[rd] = a * b; // Low 32 bits of the product
    @(posedge clk_i);
    alloc_i    <= 1'b0;
    ex_issue_i <= 1'b0;
  endtask

  task automatic alloc_only(input logic exc, input excpt_cause_t cause, input vaddr_t tval,
                            output rob_idx_t idx);
    wait_ready(0);
    claim_entry(exc, cause, tval, idx);
    @(posedge clk_i);
    alloc_i <= 1'b1;
    @(posedge clk_i);
    alloc_i <= 1'b0;
  endtask

  // Drives one memory response in the current cycle and leaves clearing mem_ready_i to the caller
  task automatic mem_drive(input rob_idx_t idx, input logic exc, input logic wr_en,
                           input reg_id_t rd, input data_t data, input excpt_cause_t cause,
                           input vaddr_t tval);
    mem_ready_i       <= 1'b1;
    mem_excpt_i       <= exc;
    mem_reg_wr_en_i   <= wr_en;
    mem_wr_reg_i      <= rd;
    data_from_mem_i   <= data;
    mem_rob_idx_i     <= idx;
    mem_excpt_cause_i <= cause;
    mem_excpt_tval_i  <= tval;
    if (!exc && wr_en && rd != '0) exp_regs[rd] = data;
  endtask

  task automatic drain_rob();
    int cycles = 0;
    while (exp_q.size() != 0 || alu_credits != ALU_DEPTH || ex_credits != 1) begin
      @(negedge clk_i);
      cycles++;
      assert (cycles < TIMEOUT) else fail_now("timed out waiting for retirement and credits");
    end
  endtask

  task automatic check_regs();
    for (int r = 0; r < NUM_REGS; r++) begin
      @(posedge clk_i);
      rd_addr_i <= reg_id_t'(r);
      @(negedge clk_i);
      assert (rd_data_o == exp_regs[r]) else fail_now($sformatf(
        "Fail rd_data_o of r%0d got %h expected %h", r, rd_data_o, exp_regs[r]));
    end
  endtask

  task automatic alu_ops_and_r0();
    data_t   r;
    data_t   a;
    data_t   b;
    alu_op_t op;
    reg_id_t rd;
    for (int i = 0; i < 12; i++) begin
      r  = next_rand();
      a  = next_rand();
      b  = next_rand();
      op = alu_op_t'(r[2:0]);
      rd = r[9:5];
      if (i == 0) rd = '0;
      if (i == 1 || i == 2) rd = 5'd9;
      if (i <= 1) op = ALU_ADD;
      if (i == 2) op = ALU_PASS_B; // Register 9 must keep the add result
      issue_alu(op, a, b, rd);
    end
    drain_rob();
    check_regs();
  endtask

  task automatic multiply_ops();
    data_t a;
    data_t b;
    for (int i = 0; i < 3; i++) begin
      a = next_rand();
      b = next_rand();
      issue_ex(a, b, reg_id_t'(a[4:0] | 5'd1));
    end
    drain_rob();
    check_regs();
  endtask

  task automatic priority_under_mem();
    rob_idx_t mem_idx [5];
    data_t    a;
    data_t    b;
    for (int i = 0; i < 5; i++) alloc_only(1'b0, '0, '0, mem_idx[i]);
    a = next_rand();
    b = next_rand();
    issue_ex(a, b, 5'd10);
    repeat (27) @(posedge clk_i); // Multiply and ALU results become ready together
    a = next_rand();
    b = next_rand();
    issue_alu(ALU_ADD, a, b, 5'd11);
    a = next_rand();
    b = next_rand();
    issue_alu(ALU_SUB, a, b, 5'd12);
    for (int k = 0; k < 5; k++) begin
      @(posedge clk_i);
      mem_drive(mem_idx[k], 1'b0, 1'b1, reg_id_t'(20 + k), next_rand(), '0, '0);
    end
    @(posedge clk_i);
    mem_ready_i <= 1'b0;
    drain_rob();
    check_regs();
  endtask

  task automatic mem_exception();
    rob_idx_t     idx;
    rob_idx_t     idx2;
    excpt_cause_t cause;
    vaddr_t       tval;
    cause = 4'hd;
    tval  = next_rand();
    alloc_only(1'b1, cause, tval, idx);
    alloc_only(1'b0, '0, '0, idx2);
    @(posedge clk_i);
    mem_drive(idx, 1'b1, 1'b1, 5'd7, next_rand(), cause, tval);
    @(posedge clk_i);
    mem_drive(idx2, 1'b0, 1'b0, 5'd8, next_rand(), '0, '0); // Completes without a write
    @(posedge clk_i);
    mem_ready_i <= 1'b0;
    drain_rob();
    check_regs();
  endtask

  task automatic credit_return();
    rob_idx_t mem_idx [ALU_DEPTH];
    data_t    a;
    data_t    b;
    for (int i = 0; i < ALU_DEPTH; i++) alloc_only(1'b0, '0, '0, mem_idx[i]);
    // Memory holds the port from the cycle the first ALU result could be granted
    for (int c = 0; c < ALU_DEPTH + 2; c++) begin
      @(posedge clk_i);
      alloc_i     <= (c < ALU_DEPTH);
      alu_issue_i <= (c < ALU_DEPTH);
      if (c < ALU_DEPTH) begin
        a = next_rand();
        b = next_rand();
        alu_op_i      <= ALU_XOR;
        alu_a_i       <= a;
        alu_b_i       <= b;
        alu_wr_reg_i  <= reg_id_t'(24 + c);
        alu_rob_idx_i <= next_idx;
        exp_q.push_back(rob_exp_t'{next_idx, 1'b0, 4'h0, 32'h0});
        next_idx++;
        alu_credits--;
        exp_regs[24 + c] = a ^ b;
      end
      if (c >= 2) mem_drive(mem_idx[c - 2], 1'b0, 1'b1, reg_id_t'(16 + c), next_rand(), '0, '0);
    end
    @(posedge clk_i);
    mem_ready_i <= 1'b0;
    @(posedge clk_i);
    assert (alu_credits == 0) else fail_now($sformatf(
      "Fail alu_credit_o pulsed while memory held the port, credits %h expected 0", alu_credits));
    drain_rob();
    check_regs();
  endtask

  task automatic retire_in_order();
    rob_idx_t fill_idx [6];
    data_t    a;
    data_t    b;
    a = next_rand();
    b = next_rand();
    issue_ex(a, b, 5'd5);
    a = next_rand();
    b = next_rand();
    issue_alu(ALU_OR, a, b, 5'd6); // Completes long before the older multiply
    for (int i = 0; i < 6; i++) begin
      alloc_only(1'b0, '0, '0, fill_idx[i]);
      @(negedge clk_i);
      assert (rob_full_o == (i == 5)) else fail_now($sformatf(
        "Fail rob_full_o got %h expected %h", rob_full_o, i == 5));
    end
    for (int i = 0; i < 6; i++) begin
      @(posedge clk_i);
      mem_drive(fill_idx[i], 1'b0, 1'b1, reg_id_t'(13 + i), next_rand(), '0, '0);
    end
    @(posedge clk_i);
    mem_ready_i <= 1'b0;
    drain_rob();
    check_regs();
  endtask

  initial begin
    clk_i = 1'b0;
    rst_i = 1'b1;
    {alu_issue_i, ex_issue_i, alloc_i, mem_ready_i, mem_excpt_i, mem_reg_wr_en_i} = '0;
    alu_op_i = ALU_ADD;
    {alu_a_i, alu_b_i, ex_a_i, ex_b_i, data_from_mem_i, mem_excpt_tval_i} = '0;
    {alu_wr_reg_i, ex_wr_reg_i, mem_wr_reg_i, rd_addr_i} = '0;
    {alu_rob_idx_i, ex_rob_idx_i, mem_rob_idx_i, mem_excpt_cause_i} = '0;
    for (int r = 0; r < NUM_REGS; r++) exp_regs[r] = '0;
    next_idx    = '0;
    alu_credits = ALU_DEPTH;
    ex_credits  = 1;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    assert (!alu_credit_o && !ex_credit_o && !retire_valid_o && !rob_full_o)
      else fail_now("an output was high right after reset");
    alu_ops_and_r0();
    multiply_ops();
    priority_under_mem();
    mem_exception();
    credit_return();
    retire_in_order();
    $display("TESTS PASSED");
    $finish;
  end

endmodule : tb_wb_core

/* wb_core.f */
src/wb_pkg.sv
src/alu_unit.sv
src/ex_unit.sv
src/wb_arbiter.sv
src/reg_file.sv
src/rob_status.sv
src/wb_core.sv
tb/tb_wb_core.sv
